/* all.f */
rtl/isa_pkg.sv
rtl/exec_pkg.sv
rtl/simple_alu.sv
rtl/operand_stage.sv
rtl/writeback_stage.sv
rtl/exec_lane.sv
sim/exec_lane_assert.sv
sim/tb_exec_lane.sv

/* run.sh */
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module tb_exec_lane -f all.f -o tb_exec_lane

out="$(./obj_dir/tb_exec_lane 2>&1 || true)"
echo "$out"

if echo "$out" | grep -qxF "=== PASS ==="; then
    exit 0
fi
exit 1

/* sim/tb_exec_lane.sv */
`timescale 1ns/1ps

module tb_exec_lane;

    localparam int DATA_W  = exec_pkg::DATA_W_DEF;
    localparam int DRAIN_T = 20;                        // Cycles allowed to empty the pipe
    localparam logic [DATA_W-1:0] SIGN_BIT = {1'b1, {(DATA_W-1){1'b0}}};

    logic                       clk;
    logic                       rst_i;
    exec_pkg::issue_pkt_t       issue_i;
    exec_pkg::result_pkt_t      result_o;

    logic [31:0]                lcg_state;
    logic [DATA_W-1:0]          model_hi;
    logic [DATA_W-1:0]          model_lo;
    logic [exec_pkg::TAG_W-1:0] next_tag;
    int unsigned                cyc;
    int unsigned                n_issued;
    int unsigned                n_checked;
    exec_pkg::result_pkt_t      exp_q[$];
    int unsigned                exp_cyc_q[$];               // Issue cycle of each entry
    isa_pkg::opcode_e           all_ops[32];

    exec_lane #(
        .DATA_W (DATA_W)
    ) i_dut (
        .clk      (clk),
        .rst_i    (rst_i),
        .issue_i  (issue_i),
        .result_o (result_o)
    );

    always #10 clk = ~clk;

    always @(posedge clk) begin
        cyc <= cyc + 1;
    end

    // --------------------
    // Failure reporting
    // --------------------

    task automatic stop_run();
        $display("=== FAIL ===");
        $fatal(1, "stopped at first error");
    endtask

    task automatic report_mismatch(input string name, input logic [DATA_W-1:0] got,
                                   input logic [DATA_W-1:0] want);
        $display("ERROR time %0t: %s is %h, expected %h", $time, name, got, want);
        stop_run();
    endtask

    task automatic report_failure(input string what);
        $display("%s (time %0t)", what, $time);
        stop_run();
    endtask

    // --------------------
    // Stimulus helpers
    // --------------------

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic logic [DATA_W-1:0] pick_operand();
        logic [31:0] r;
        r = lcg_next();
        case (r[31:29])
            3'd0:    return '0;
            3'd1:    return '1;
            3'd2:    return 32'h7fffffff;
            3'd3:    return 32'h80000000;
            default: return lcg_next();
        endcase
    endfunction

    function automatic logic [isa_pkg::IMM_W-1:0] pick_imm();
        logic [31:0] r;
        r = lcg_next();
        case (r[31:30])
            2'd0:    return 16'h7fff;
            2'd1:    return 16'h8000;
            default: return r[23:8];
        endcase
    endfunction

    function automatic logic [DATA_W-1:0] shift_right_arith(input logic [DATA_W-1:0] v,
                                                            input logic [4:0] sh);
        return (v >> sh) | ({DATA_W{v[DATA_W-1]}} & ~({DATA_W{1'b1}} >> sh));
    endfunction

    // --------------------
    // Reference model
    // --------------------

    function automatic exec_pkg::result_pkt_t ref_exec(input exec_pkg::issue_pkt_t pkt,
                                                       input logic [DATA_W-1:0] hi,
                                                       input logic [DATA_W-1:0] lo);
        exec_pkg::result_pkt_t r;
        logic [DATA_W-1:0]     a;
        logic [DATA_W-1:0]     b;
        logic [DATA_W-1:0]     simm;
        logic [DATA_W-1:0]     zimm;
        logic [DATA_W:0]       wide;
        logic                  ovf;
        a    = pkt.data1;
        b    = pkt.data2;
        simm = {{(DATA_W-16){pkt.immd[15]}}, pkt.immd};
        zimm = {{(DATA_W-16){1'b0}}, pkt.immd};
        wide = '0;
        r.valid          = pkt.valid;
        r.tag            = pkt.tag;
        r.result         = '0;
        r.flags.executed = (pkt.opcode != isa_pkg::OP_NOP);
        case (pkt.opcode)
            isa_pkg::OP_ADD, isa_pkg::OP_ADDU: wide = {a[DATA_W-1], a} + {b[DATA_W-1], b};
            isa_pkg::OP_ADDI, isa_pkg::OP_ADDIU: wide = {a[DATA_W-1], a} + {simm[DATA_W-1], simm};
            isa_pkg::OP_SUB, isa_pkg::OP_SUBU: wide = {a[DATA_W-1], a} - {b[DATA_W-1], b};
            isa_pkg::OP_MFHI:  r.result = hi;
            isa_pkg::OP_MFLO:  r.result = lo;
            isa_pkg::OP_MTHI, isa_pkg::OP_MTLO: r.result = a;
            isa_pkg::OP_AND:   r.result = a & b;
            isa_pkg::OP_ANDI:  r.result = a & zimm;
            isa_pkg::OP_OR:    r.result = a | b;
            isa_pkg::OP_ORI:   r.result = a | zimm;
            isa_pkg::OP_XOR:   r.result = a ^ b;
            isa_pkg::OP_XORI:  r.result = a ^ zimm;
            isa_pkg::OP_NOR:   r.result = ~(a | b);
            isa_pkg::OP_SLL:   r.result = a << pkt.immd[4:0];
            isa_pkg::OP_SLLV:  r.result = b << a[4:0];
            isa_pkg::OP_SRL:   r.result = a >> pkt.immd[4:0];
            isa_pkg::OP_SRLV:  r.result = b >> a[4:0];
            isa_pkg::OP_SRA:   r.result = shift_right_arith(a, pkt.immd[4:0]);
            isa_pkg::OP_SRAV:  r.result = shift_right_arith(b, a[4:0]);
            isa_pkg::OP_SLT:   r.result = DATA_W'((a ^ SIGN_BIT) < (b ^ SIGN_BIT));  // Bias to unsigned
            isa_pkg::OP_SLTI:  r.result = DATA_W'((a ^ SIGN_BIT) < (simm ^ SIGN_BIT));
            isa_pkg::OP_SLTU:  r.result = DATA_W'(a < b);
            isa_pkg::OP_SLTIU: r.result = DATA_W'(a < zimm);
            isa_pkg::OP_LUI:   r.result = {pkt.immd, 16'h0000};
            default: ;
        endcase
        if (pkt.opcode inside {isa_pkg::OP_ADD, isa_pkg::OP_ADDU, isa_pkg::OP_ADDI,
                               isa_pkg::OP_ADDIU, isa_pkg::OP_SUB, isa_pkg::OP_SUBU}) begin
            r.result = wide[DATA_W-1:0];
        end
        ovf = (wide[DATA_W] != wide[DATA_W-1]);        // Sign lost in 33-bit sum
        r.flags.exception = ovf && (pkt.opcode inside {isa_pkg::OP_ADD, isa_pkg::OP_ADDI,
                                                       isa_pkg::OP_SUB});
        return r;
    endfunction

    // --------------------
    // Driving
    // --------------------

    task automatic issue_op(input isa_pkg::opcode_e op, input logic [DATA_W-1:0] d1,
                            input logic [DATA_W-1:0] d2,
                            input logic [isa_pkg::IMM_W-1:0] imm, input logic valid);
        exec_pkg::issue_pkt_t pkt;
        @(posedge clk);
        #1;
        pkt.valid  = valid;
        pkt.opcode = op;
        pkt.data1  = d1;
        pkt.data2  = d2;
        pkt.immd   = imm;
        pkt.tag    = next_tag;
        issue_i    = pkt;
        if (valid) begin
            exp_q.push_back(ref_exec(pkt, model_hi, model_lo));
            exp_cyc_q.push_back(cyc);
            n_issued++;
            next_tag = next_tag + 1'b1;
            if (op == isa_pkg::OP_MTHI) begin
                model_hi = d1;                         // Model follows issue order
            end
            if (op == isa_pkg::OP_MTLO) begin
                model_lo = d1;
            end
        end
    endtask

    task automatic issue_rand(input isa_pkg::opcode_e op, input logic valid);
        issue_op(op, pick_operand(), pick_operand(), pick_imm(), valid);
    endtask

    task automatic check_idle(input int cycles);
        for (int n = 0; n < cycles; n++) begin
            @(negedge clk);
            if (result_o.valid !== 1'b0) begin
                report_mismatch("result_o.valid", DATA_W'(result_o.valid), '0);
            end
        end
    endtask

    task automatic drain_results();
        int waited;
        waited = 0;
        while (exp_q.size() != 0 && waited < DRAIN_T) begin
            @(negedge clk);
            waited++;
        end
        if (exp_q.size() != 0) begin
            report_failure("Timeout waiting for outstanding results");
        end
    endtask

    // --------------------
    // Checking
    // --------------------

    task automatic check_result(input exec_pkg::result_pkt_t got,
                                input exec_pkg::result_pkt_t want);
        if (got.valid !== want.valid) begin
            report_mismatch("result_o.valid", DATA_W'(got.valid), DATA_W'(want.valid));
        end
        if (got.tag !== want.tag) begin
            report_mismatch("result_o.tag", DATA_W'(got.tag), DATA_W'(want.tag));
        end
        if (got.result !== want.result) begin
            report_mismatch("result_o.result", got.result, want.result);
        end
    endtask

    task automatic check_flags(input exec_pkg::exec_flags_t got,
                               input exec_pkg::exec_flags_t want);
        if (got.executed !== want.executed) begin
            report_mismatch("result_o.flags.executed", DATA_W'(got.executed),
                            DATA_W'(want.executed));
        end
        if (got.exception !== want.exception) begin
            report_mismatch("result_o.flags.exception", DATA_W'(got.exception),
                            DATA_W'(want.exception));
        end
    endtask

    always @(negedge clk) begin : compare_results
        exec_pkg::result_pkt_t exp_pkt;
        int unsigned           exp_cyc;
        if (!rst_i && result_o.valid === 1'b1) begin
            if (exp_q.size() == 0) begin
                report_failure("Result appeared with no packet in flight");
            end else begin
                exp_pkt = exp_q.pop_front();
                exp_cyc = exp_cyc_q.pop_front();
                if (cyc != exp_cyc + 2) begin
                    report_failure("Result arrived at the wrong cycle");
                end else begin
                    check_result(result_o, exp_pkt);
                    check_flags(result_o.flags, exp_pkt.flags);
                    n_checked++;
                end
            end
        end
    end

    // --------------------
    // Test sequence
    // --------------------

    initial begin
        logic [31:0]       rnd;
        logic [DATA_W-1:0] word;
        clk       = 1'b0;
        rst_i     = 1'b1;
        issue_i   = '0;
        lcg_state = 32'hc554;
        model_hi  = '0;
        model_lo  = '0;
        next_tag  = '0;
        cyc       = 0;
        n_issued  = 0;
        n_checked = 0;
        all_ops   = '{isa_pkg::OP_ADD, isa_pkg::OP_ADDI, isa_pkg::OP_ADDU, isa_pkg::OP_ADDIU,
                      isa_pkg::OP_SUB, isa_pkg::OP_SUBU, isa_pkg::OP_AND, isa_pkg::OP_ANDI,
                      isa_pkg::OP_OR, isa_pkg::OP_ORI, isa_pkg::OP_XOR, isa_pkg::OP_XORI,
                      isa_pkg::OP_NOR, isa_pkg::OP_LUI, isa_pkg::OP_SLL, isa_pkg::OP_SLLV,
                      isa_pkg::OP_SRL, isa_pkg::OP_SRLV, isa_pkg::OP_SRA, isa_pkg::OP_SRAV,
                      isa_pkg::OP_SLT, isa_pkg::OP_SLTI, isa_pkg::OP_SLTU, isa_pkg::OP_SLTIU,
                      isa_pkg::OP_MFHI, isa_pkg::OP_MTHI, isa_pkg::OP_MFLO, isa_pkg::OP_MTLO,
                      isa_pkg::OP_NOP, isa_pkg::OP_NOP, isa_pkg::OP_NOP, isa_pkg::OP_MFHI};
        repeat (5) @(posedge clk);
        #1;
        rst_i = 1'b0;
        check_idle(8);

        // Overflow corners, then arithmetic and logical ops (first 14 entries)
        issue_op(isa_pkg::OP_ADD, 32'h7fffffff, 32'h00000001, 16'h0000, 1'b1);
        issue_op(isa_pkg::OP_ADD, 32'h80000000, 32'h80000000, 16'h0000, 1'b1);
        issue_op(isa_pkg::OP_SUB, 32'h80000000, 32'h00000001, 16'h0000, 1'b1);
        issue_op(isa_pkg::OP_SUB, 32'h7fffffff, 32'hffffffff, 16'h0000, 1'b1);
        issue_op(isa_pkg::OP_ADDI, 32'h7fffffff, 32'h0, 16'h0001, 1'b1);
        issue_op(isa_pkg::OP_ADDI, 32'h80000000, 32'h0, 16'hffff, 1'b1);
        for (int i = 0; i < 14; i++) begin
            for (int n = 0; n < 12; n++) begin
                issue_rand(all_ops[i[4:0]], 1'b1);
            end
        end

        // Every shift amount for fixed and variable forms
        for (int sh = 0; sh < 32; sh++) begin
            rnd  = lcg_next();
            word = pick_operand() | (sh[0] ? SIGN_BIT : '0);
            issue_op(isa_pkg::OP_SLL, word, rnd, {rnd[20:10], sh[4:0]}, 1'b1);
            issue_op(isa_pkg::OP_SRL, word, rnd, {rnd[20:10], sh[4:0]}, 1'b1);
            issue_op(isa_pkg::OP_SRA, word, rnd, {rnd[20:10], sh[4:0]}, 1'b1);
            issue_op(isa_pkg::OP_SLLV, {rnd[31:5], sh[4:0]}, word, rnd[15:0], 1'b1);
            issue_op(isa_pkg::OP_SRLV, {rnd[31:5], sh[4:0]}, word, rnd[15:0], 1'b1);
            issue_op(isa_pkg::OP_SRAV, {rnd[31:5], sh[4:0]}, word, rnd[15:0], 1'b1);
        end

        // Signed against unsigned compares
        issue_op(isa_pkg::OP_SLT, 32'h80000000, 32'h00000001, 16'h0000, 1'b1);
        issue_op(isa_pkg::OP_SLTU, 32'h80000000, 32'h00000001, 16'h0000, 1'b1);
        issue_op(isa_pkg::OP_SLTI, 32'hffffffff, 32'h0, 16'h0001, 1'b1);
        issue_op(isa_pkg::OP_SLTIU, 32'hffffffff, 32'h0, 16'h0001, 1'b1);
        for (int n = 0; n < 24; n++) begin
            issue_rand(isa_pkg::OP_SLT, 1'b1);
            issue_rand(isa_pkg::OP_SLTU, 1'b1);
            issue_rand(isa_pkg::OP_SLTI, 1'b1);
            issue_rand(isa_pkg::OP_SLTIU, 1'b1);
        end

        // HI/LO back to back, an invalid MTHI must not write
        for (int n = 0; n < 6; n++) begin
            issue_rand(isa_pkg::OP_MTHI, 1'b1);
            issue_rand(isa_pkg::OP_MFHI, 1'b1);
            issue_rand(isa_pkg::OP_MTLO, 1'b1);
            issue_rand(isa_pkg::OP_MFLO, 1'b1);
            issue_rand(isa_pkg::OP_MFHI, 1'b1);
            issue_rand(isa_pkg::OP_MTHI, 1'b0);
            issue_rand(isa_pkg::OP_MFHI, 1'b1);
            issue_rand(isa_pkg::OP_MTLO, 1'b1);
            issue_rand(isa_pkg::OP_MTHI, 1'b1);
            issue_rand(isa_pkg::OP_MFLO, 1'b1);
            issue_rand(isa_pkg::OP_MFHI, 1'b1);
        end

        // Mixed stream with gaps and NOPs
        for (int n = 0; n < 300; n++) begin
            rnd = lcg_next();
            issue_rand(all_ops[rnd[31:27]], rnd[26:25] != 2'b00);
        end

        issue_op(isa_pkg::OP_NOP, '0, '0, '0, 1'b0);
        drain_results();
        check_idle(6);
        if (n_checked == n_issued && exp_q.size() == 0) begin
            $display("=== PASS ===");
            $finish;
        end else begin
            report_failure("Number of results does not match number of valid issues");
        end
    end

endmodule

/* sim/exec_lane_assert.sv */
`timescale 1ns/1ps

module exec_lane_assert (
    input logic                  clk,
    input logic                  rst_i,
    input exec_pkg::issue_pkt_t  issue_i,
    input exec_pkg::issue_pkt_t  op_i,
    input exec_pkg::hilo_wr_t    hilo_wr_i,
    input exec_pkg::result_pkt_t result_i
);

    // --------------------
    // Properties
    // --------------------

    property p_reset_clears_valid;
        @(posedge clk) rst_i |=> (!result_i.valid && !op_i.valid);
    endproperty

    // Fixed two-cycle latency once reset is well behind
    property p_valid_latency;
        @(posedge clk) disable iff (rst_i)
            (!$past(rst_i) && !$past(rst_i, 2)) |-> (result_i.valid == $past(issue_i.valid, 2));
    endproperty

    // A write traces back to a valid MTHI or MTLO issued one cycle earlier
    property p_hilo_write_needs_valid;
        @(posedge clk) disable iff (rst_i)
            (hilo_wr_i.hi_we || hilo_wr_i.lo_we) |->
                ($past(issue_i.valid) &&
                 (($past(issue_i.opcode) == isa_pkg::OP_MTHI) ||
                  ($past(issue_i.opcode) == isa_pkg::OP_MTLO)));
    endproperty

    a_reset_clears_valid: assert property (p_reset_clears_valid)
        else $error("valid bits not cleared by reset");
    a_valid_latency: assert property (p_valid_latency)
        else $error("result valid does not follow issue valid by two cycles");
    a_hilo_write_needs_valid: assert property (p_hilo_write_needs_valid)
        else $error("HI/LO write without a valid packet in writeback");

endmodule

bind exec_lane exec_lane_assert u_exec_lane_assert (
    .clk       (clk),
    .rst_i     (rst_i),
    .issue_i   (issue_i),
    .op_i      (op_pkt),
    .hilo_wr_i (hilo_wr),
    .result_i  (result_o)
);

/* rtl/exec_lane.sv */
`timescale 1ns/1ps

module exec_lane #(
    parameter int DATA_W = exec_pkg::DATA_W_DEF
) (
    input  logic                  clk,
    input  logic                  rst_i,
    input  exec_pkg::issue_pkt_t  issue_i,
    output exec_pkg::result_pkt_t result_o
);

    exec_pkg::issue_pkt_t  op_pkt;         // Stage 1 packet into the ALU
    logic [DATA_W-1:0]     alu_result;
    exec_pkg::exec_flags_t alu_flags;
    exec_pkg::hilo_wr_t    hilo_wr;        // Feedback from writeback

    operand_stage #(
        .DATA_W (DATA_W)
    ) u_operand_stage (
        .clk       (clk),
        .rst_i     (rst_i),
        .issue_i   (issue_i),
        .hilo_wr_i (hilo_wr),
        .op_o      (op_pkt)
    );

    simple_alu #(
        .DATA_W (DATA_W)
    ) u_simple_alu (
        .op_i     (op_pkt),
        .result_o (alu_result),
        .flags_o  (alu_flags)
    );

    writeback_stage #(
        .DATA_W (DATA_W)
    ) u_writeback_stage (
        .clk          (clk),
        .rst_i        (rst_i),
        .op_i         (op_pkt),
        .alu_result_i (alu_result),
        .alu_flags_i  (alu_flags),
        .result_o     (result_o),
        .hilo_wr_o    (hilo_wr)
    );

endmodule

/* rtl/writeback_stage.sv */
`timescale 1ns/1ps

module writeback_stage #(
    parameter int DATA_W = exec_pkg::DATA_W_DEF
) (
    input  logic                  clk,
    input  logic                  rst_i,
    input  exec_pkg::issue_pkt_t  op_i,
    input  logic [DATA_W-1:0]     alu_result_i,
    input  exec_pkg::exec_flags_t alu_flags_i,
    output exec_pkg::result_pkt_t result_o,
    output exec_pkg::hilo_wr_t    hilo_wr_o
);

    logic                            valid_q;
    logic [exec_pkg::TAG_W-1:0]      tag_q;
    logic [exec_pkg::DATA_W_DEF-1:0] result_q;
    exec_pkg::exec_flags_t           flags_q;

    always_ff @(posedge clk) begin
        if (rst_i) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= op_i.valid;
        end
    end

    always_ff @(posedge clk) begin
        tag_q    <= op_i.tag;
        result_q <= alu_result_i[exec_pkg::DATA_W_DEF-1:0];
        flags_q  <= alu_flags_i;
    end

    always_comb begin
        result_o.valid  = valid_q;
        result_o.tag    = tag_q;
        result_o.result = result_q;
        result_o.flags  = flags_q;
    end

    // HI/LO write lands on the edge that loads result_q
    always_comb begin
        hilo_wr_o.hi_we = op_i.valid && (op_i.opcode == isa_pkg::OP_MTHI);
        hilo_wr_o.lo_we = op_i.valid && (op_i.opcode == isa_pkg::OP_MTLO);
        hilo_wr_o.data  = alu_result_i[exec_pkg::DATA_W_DEF-1:0];
    end

endmodule

/* rtl/operand_stage.sv */
`timescale 1ns/1ps

module operand_stage #(
    parameter int DATA_W = exec_pkg::DATA_W_DEF
) (
    input  logic                 clk,
    input  logic                 rst_i,
    input  exec_pkg::issue_pkt_t issue_i,
    input  exec_pkg::hilo_wr_t   hilo_wr_i,
    output exec_pkg::issue_pkt_t op_o
);

    logic                 valid_q;
    exec_pkg::issue_pkt_t pkt_q;
    logic [DATA_W-1:0]    hi_q;
    logic [DATA_W-1:0]    lo_q;

    // --------------------
    // Issue register
    // --------------------

    always_ff @(posedge clk) begin
        if (rst_i) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= issue_i.valid;
        end
    end

    always_ff @(posedge clk) begin
        pkt_q <= issue_i;                  // Payload, qualified by valid_q
    end

    // --------------------
    // HI and LO
    // --------------------

    always_ff @(posedge clk) begin
        if (rst_i) begin
            hi_q <= '0;
            lo_q <= '0;
        end else begin
            if (hilo_wr_i.hi_we) begin
                hi_q <= DATA_W'(hilo_wr_i.data);
            end
            if (hilo_wr_i.lo_we) begin
                lo_q <= DATA_W'(hilo_wr_i.data);
            end
        end
    end

    // Read after the write edge, so an MTHI just ahead is already visible
    always_comb begin
        op_o       = pkt_q;
        op_o.valid = valid_q;
        if (pkt_q.opcode == isa_pkg::OP_MFHI) begin
            op_o.data1 = hi_q[exec_pkg::DATA_W_DEF-1:0];
        end else if (pkt_q.opcode == isa_pkg::OP_MFLO) begin
            op_o.data1 = lo_q[exec_pkg::DATA_W_DEF-1:0];
        end
    end

endmodule

/* rtl/simple_alu.sv */
`timescale 1ns/1ps

module simple_alu #(
    parameter int DATA_W = exec_pkg::DATA_W_DEF
) (
    input  exec_pkg::issue_pkt_t  op_i,
    output logic [DATA_W-1:0]     result_o,
    output exec_pkg::exec_flags_t flags_o
);

    // --------------------
    // Operand extension
    // --------------------

    logic [DATA_W-1:0] a_s;
    logic [DATA_W-1:0] a_u;
    logic [DATA_W-1:0] b_s;
    logic [DATA_W-1:0] b_u;
    logic [DATA_W-1:0] imm_sx;
    logic [DATA_W-1:0] imm_zx;
    logic [DATA_W-1:0] lui_val;
    logic [DATA_W-1:0] sum_ab;
    logic [DATA_W-1:0] sum_ai;
    logic [DATA_W-1:0] diff_ab;
    logic              ovf_add;
    logic              ovf_addi;
    logic              ovf_sub;
    logic [4:0]        shamt_v;
    logic [4:0]        shamt_i;

    assign a_s     = DATA_W'(signed'(op_i.data1));      // Signed view of data1
    assign a_u     = DATA_W'(op_i.data1);
    assign b_s     = DATA_W'(signed'(op_i.data2));
    assign b_u     = DATA_W'(op_i.data2);
    assign imm_sx  = DATA_W'(signed'(op_i.immd));
    assign imm_zx  = DATA_W'(op_i.immd);
    assign lui_val = DATA_W'(signed'({op_i.immd, {isa_pkg::IMM_W{1'b0}}}));

    assign shamt_v = op_i.data1[4:0];                   // Variable shifts take rs
    assign shamt_i = op_i.immd[4:0];                    // Fixed shifts take shamt

    // Overflow when both operands agree in sign and the sum does not
    assign sum_ab   = a_s + b_s;
    assign sum_ai   = a_s + imm_sx;
    assign diff_ab  = a_s - b_s;
    assign ovf_add  = (a_s[DATA_W-1] == b_s[DATA_W-1]) && (sum_ab[DATA_W-1] != a_s[DATA_W-1]);
    assign ovf_addi = (a_s[DATA_W-1] == imm_sx[DATA_W-1]) &&
                      (sum_ai[DATA_W-1] != a_s[DATA_W-1]);
    assign ovf_sub  = (a_s[DATA_W-1] != b_s[DATA_W-1]) &&
                      (diff_ab[DATA_W-1] != a_s[DATA_W-1]);

    // --------------------
    // Operation select
    // --------------------

    always_comb begin
        result_o          = '0;
        flags_o.executed  = 1'b1;
        flags_o.exception = 1'b0;
        case (op_i.opcode)
            isa_pkg::OP_ADD: begin
                result_o          = sum_ab;
                flags_o.exception = ovf_add;
            end
            isa_pkg::OP_ADDI: begin
                result_o          = sum_ai;
                flags_o.exception = ovf_addi;
            end
            isa_pkg::OP_ADDU:  result_o = sum_ab;      // Same sum, no trap
            isa_pkg::OP_ADDIU: result_o = sum_ai;
            isa_pkg::OP_SUB: begin
                result_o          = diff_ab;
                flags_o.exception = ovf_sub;
            end
            isa_pkg::OP_SUBU:  result_o = diff_ab;
            isa_pkg::OP_MFHI,
            isa_pkg::OP_MTHI,
            isa_pkg::OP_MFLO,
            isa_pkg::OP_MTLO:  result_o = a_u;         // HI/LO already in data1
            isa_pkg::OP_AND:   result_o = a_u & b_u;
            isa_pkg::OP_ANDI:  result_o = a_u & imm_zx;
            isa_pkg::OP_OR:    result_o = a_u | b_u;
            isa_pkg::OP_ORI:   result_o = a_u | imm_zx;
            isa_pkg::OP_XOR:   result_o = a_u ^ b_u;
            isa_pkg::OP_XORI:  result_o = a_u ^ imm_zx;
            isa_pkg::OP_NOR:   result_o = ~(a_u | b_u);
            isa_pkg::OP_SLL:   result_o = a_u << shamt_i;
            isa_pkg::OP_SLLV:  result_o = b_u << shamt_v;
            isa_pkg::OP_SRL:   result_o = a_u >> shamt_i;
            isa_pkg::OP_SRLV:  result_o = b_u >> shamt_v;
            isa_pkg::OP_SRA:   result_o = $signed(a_s) >>> shamt_i;
            isa_pkg::OP_SRAV:  result_o = $signed(b_s) >>> shamt_v;
            isa_pkg::OP_SLT:   result_o = DATA_W'($signed(a_s) < $signed(b_s));
            isa_pkg::OP_SLTI:  result_o = DATA_W'($signed(a_s) < $signed(imm_sx));
            isa_pkg::OP_SLTU:  result_o = DATA_W'(a_u < b_u);
            // Unsigned compare against the zero-extended immediate
            isa_pkg::OP_SLTIU: result_o = DATA_W'(a_u < imm_zx);
            isa_pkg::OP_LUI:   result_o = lui_val;
            isa_pkg::OP_NOP:   flags_o.executed = 1'b0;
            default:           flags_o.executed = 1'b0;  // Unknown opcode does nothing
        endcase
    end

endmodule

/* rtl/exec_pkg.sv */
package exec_pkg;

    parameter int DATA_W_DEF = 32;         // Default datapath width
    parameter int TAG_W      = 6;          // Destination tag width

    // --------------------
    // Lane packets
    // --------------------

    typedef struct packed {
        logic executed;                    // Any opcode other than NOP
        logic exception;                   // Signed overflow of ADD, ADDI, SUB
    } exec_flags_t;

    typedef struct packed {
        logic                        valid;
        isa_pkg::opcode_e            opcode;
        logic [DATA_W_DEF-1:0]       data1;
        logic [DATA_W_DEF-1:0]       data2;
        logic [isa_pkg::IMM_W-1:0]   immd;
        logic [TAG_W-1:0]            tag;
    } issue_pkt_t;

    typedef struct packed {
        logic                  valid;
        logic [TAG_W-1:0]      tag;
        logic [DATA_W_DEF-1:0] result;
        exec_flags_t           flags;
    } result_pkt_t;

    // Write request from writeback back to the HI/LO registers
    typedef struct packed {
        logic                  hi_we;
        logic                  lo_we;
        logic [DATA_W_DEF-1:0] data;
    } hilo_wr_t;

endpackage

/* rtl/isa_pkg.sv */
package isa_pkg;

    // --------------------
    // Instruction fields
    // --------------------

    parameter int IMM_W = 16;              // Immediate field width

    // --------------------
    // Opcodes
    // --------------------

    typedef enum logic [5:0] {
        OP_NOP   = 6'h00,
        OP_ADD   = 6'h01,
        OP_ADDI  = 6'h02,
        OP_ADDU  = 6'h03,
        OP_ADDIU = 6'h04,
        OP_SUB   = 6'h05,
        OP_SUBU  = 6'h06,
        OP_MFHI  = 6'h08,                  // HI/LO moves
        OP_MTHI  = 6'h09,
        OP_MFLO  = 6'h0a,
        OP_MTLO  = 6'h0b,
        OP_AND   = 6'h10,                  // Logical
        OP_ANDI  = 6'h11,
        OP_OR    = 6'h12,
        OP_ORI   = 6'h13,
        OP_XOR   = 6'h14,
        OP_XORI  = 6'h15,
        OP_NOR   = 6'h16,
        OP_SLL   = 6'h18,                  // Shifts
        OP_SLLV  = 6'h19,
        OP_SRL   = 6'h1a,
        OP_SRLV  = 6'h1b,
        OP_SRA   = 6'h1c,
        OP_SRAV  = 6'h1d,
        OP_SLT   = 6'h20,                  // Set on less than
        OP_SLTI  = 6'h21,
        OP_SLTU  = 6'h22,
        OP_SLTIU = 6'h23,
        OP_LUI   = 6'h28
    } opcode_e;

endpackage
